// ==== bench/xp10_decomp_ref.svh ====
`ifndef XP10_DECOMP_REF_SVH
`define XP10_DECOMP_REF_SVH

typedef stream_beat_t beat_q_t[$];

// Appends one TLV of len words. The type code sits in bits 7:0 of the first word.
function automatic beat_q_t add_tlv(beat_q_t q, bit is_ftr, int len);
   stream_beat_t b;
   int i;
   for (i = 0; i < len; i++) begin
      b.tdata = {$urandom, $urandom};
      b.tuser = {i == len - 1, i == 0};
      b.tlast = is_ftr && (i == len - 1);  // A footer closes the frame.
      if (i == 0) b.tdata[7:0] = is_ftr ? TLV_TYPE_FTR : 8'(1 + $urandom % 8);
      q.push_back(b);
   end
   return q;
endfunction

// Each frame is up to two short data TLVs followed by one footer.
function automatic beat_q_t build_frames(int n_frames, int ftr_min, int ftr_max);
   beat_q_t q;
   int n_data;
   int f;
   int d;
   for (f = 0; f < n_frames; f++) begin
      n_data = $urandom % 3;
      for (d = 0; d < n_data; d++) q = add_tlv(q, 1'b0, 1 + $urandom % 6);
      q = add_tlv(q, 1'b1, ftr_min + $urandom % (ftr_max - ftr_min + 1));
   end
   return q;
endfunction

function automatic beat_q_t expect_frames(beat_q_t q, bit fixup);
   beat_q_t exp;
   stream_beat_t b;
   bit in_ftr;
   int idx;
   in_ftr = 1'b0;
   idx = 0;
   foreach (q[i]) begin
      b = q[i];
      if (b.tuser[0]) begin
         in_ftr = (b.tdata[7:0] == TLV_TYPE_FTR);
         idx = 0;
      end
      // In stored mode bytes_out equals bytes_in.
      if (fixup && in_ftr && idx == FTR_WORD_IDX) b.tdata[63:32] = b.tdata[31:0];
      exp.push_back(b);
      idx++;
   end
   return exp;
endfunction

function automatic int count_tlvs(beat_q_t q);
   int n;
   n = 0;
   foreach (q[i]) if (q[i].tuser[0]) n++;
   return n;
endfunction

function automatic int count_ftrs(beat_q_t q);
   int n;
   n = 0;
   foreach (q[i]) if (q[i].tuser[0] && q[i].tdata[7:0] == TLV_TYPE_FTR) n++;
   return n;
endfunction

// A footer that ends before its byte count word is an error.
function automatic int count_errs(beat_q_t q);
   bit in_ftr;
   int idx;
   int n;
   in_ftr = 1'b0;
   idx = 0;
   n = 0;
   foreach (q[i]) begin
      if (q[i].tuser[0]) begin
         in_ftr = (q[i].tdata[7:0] == TLV_TYPE_FTR);
         idx = 0;
      end
      if (in_ftr && q[i].tuser[1] && idx < FTR_WORD_IDX) n++;
      idx++;
   end
   return n;
endfunction

`endif

// ==== bench/xp10_decomp_tb.sv ====
module xp10_decomp_tb;
   timeunit 1ns;
   timeprecision 1ps;

   import xp10_decomp_pkg::*;

   `include "xp10_decomp_ref.svh"

   localparam logic [MODULE_ID_W-1:0] TEST_ID = 8'ha7;

   logic                   clk = 1'b0;
   logic                   rst_n;
   logic                   ib_tvalid;
   logic                   ib_tready;
   logic [DATA_W-1:0]      ib_tdata;
   logic [USER_W-1:0]      ib_tuser;
   logic                   ib_tlast;
   logic                   ob_tvalid;
   logic                   ob_tready;
   logic [DATA_W-1:0]      ob_tdata;
   logic [USER_W-1:0]      ob_tuser;
   logic                   ob_tlast;
   logic                   wb_cyc;
   logic                   wb_stb;
   logic                   wb_we;
   logic [WB_ADR_W-1:0]    wb_adr;
   logic [WB_DAT_W-1:0]    wb_dat_w;
   logic [WB_DAT_W-1:0]    wb_dat_r;
   logic                   wb_ack;
   logic [MODULE_ID_W-1:0] module_id;
   logic                   decomp_int;

   beat_q_t             frames_a;
   beat_q_t             frames_b;
   beat_q_t             frames_c;
   beat_q_t             frames_d;
   beat_q_t             exp_q;
   stream_beat_t        exp_beat;
   logic [WB_DAT_W-1:0] rd;
   bit                  rand_ready = 1'b0;
   int unsigned         cycles = 0;
   int unsigned         cycle_limit;
   int                  errors = 0;

   xp10_decomp xp10_decomp_inst (.*);

   always #20 clk = ~clk;

   task automatic compare(input string name, input logic [63:0] expected,
                          input logic [63:0] actual);
      if (actual !== expected) begin
         errors++;
         $display("Error: %s expected 0x%0h, got 0x%0h", name, expected, actual);
         $display("Some tests failed");
         $fatal(1, "Stopped at the first mismatch.");
      end
   endtask

   task automatic bus_cycle(input bit we, input logic [WB_ADR_W-1:0] adr,
                            input logic [WB_DAT_W-1:0] wdata,
                            output logic [WB_DAT_W-1:0] rdata);
      wb_cyc   = 1'b1;
      wb_stb   = 1'b1;
      wb_we    = we;
      wb_adr   = adr;
      wb_dat_w = wdata;
      @(posedge clk);
      while (!wb_ack) @(posedge clk);
      rdata = wb_dat_r;  // Valid while ack is high.
      #2;
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      wb_we  = 1'b0;
   endtask

   task automatic write_reg(input logic [WB_ADR_W-1:0] adr, input logic [WB_DAT_W-1:0] data);
      logic [WB_DAT_W-1:0] unused;
      bus_cycle(1'b1, adr, data, unused);
   endtask

   task automatic read_reg(input logic [WB_ADR_W-1:0] adr, output logic [WB_DAT_W-1:0] data);
      bus_cycle(1'b0, adr, '0, data);
   endtask

   task automatic send_words(input beat_q_t q, input bit gaps);
      int gap;
      foreach (q[i]) begin
         gap = (gaps && ($urandom % 4 == 0)) ? 1 + $urandom % 3 : 0;
         if (gap > 0) ib_tvalid = 1'b0;
         repeat (gap) begin
            @(posedge clk);
            #2;
         end
         ib_tvalid = 1'b1;
         ib_tdata  = q[i].tdata;
         ib_tuser  = q[i].tuser;
         ib_tlast  = q[i].tlast;
         @(posedge clk);
         while (!ib_tready) @(posedge clk);
         #2;
      end
      ib_tvalid = 1'b0;
   endtask

   // Queues the expected words, sends the frames and waits until all came out.
   task automatic run_frames(input beat_q_t q, input bit fixup, input bit gaps);
      beat_q_t exp;
      exp = expect_frames(q, fixup);
      foreach (exp[i]) exp_q.push_back(exp[i]);
      send_words(q, gaps);
      while (exp_q.size() != 0) @(posedge clk);
      #2;
   endtask

   task automatic check_int(input logic expected);
      repeat (2) @(posedge clk);
      #2;
      compare("decomp_int", expected, decomp_int);
   endtask

   always @(posedge clk) begin
      #2;
      ob_tready = rand_ready ? ($urandom % 3 != 0) : 1'b1;
   end

   always @(posedge clk) begin
      if (ob_tvalid && ob_tready) begin
         if (exp_q.size() == 0) begin
            $display("An output word arrived when none was expected.");
            $display("Some tests failed");
            $fatal(1, "Unexpected output word.");
         end else begin
            exp_beat = exp_q.pop_front();
            compare("ob_tdata", exp_beat.tdata, ob_tdata);
            compare("ob_tuser", exp_beat.tuser, ob_tuser);
            compare("ob_tlast", exp_beat.tlast, ob_tlast);
         end
      end
   end

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= cycle_limit) begin
         $display("Timeout after %0d cycles, the stream did not drain.", cycles);
         $display("Some tests failed");
         $fatal(1, "Simulation timed out.");
      end
   end

   initial begin
      void'($urandom(32'hec23_9a9b));
      rst_n     = 1'b0;
      ib_tvalid = 1'b0;
      ib_tdata  = '0;
      ib_tuser  = '0;
      ib_tlast  = 1'b0;
      ob_tready = 1'b1;
      wb_cyc    = 1'b0;
      wb_stb    = 1'b0;
      wb_we     = 1'b0;
      wb_adr    = '0;
      wb_dat_w  = '0;
      module_id = TEST_ID;
      frames_a = build_frames(10, 13, 16);
      frames_b = build_frames(6, 13, 16);
      frames_c = build_frames(12, 13, 16);
      frames_d = add_tlv(frames_d, 1'b0, 3);
      frames_d = add_tlv(frames_d, 1'b1, 8);  // Ends before word 12.
      cycle_limit = 4 * (frames_a.size() + frames_b.size() + frames_c.size() +
                         frames_d.size()) + 2000;
      repeat (16) @(posedge clk);
      #2 rst_n = 1'b1;
      while (!ib_tready) @(posedge clk);
      #2;

      read_reg(REG_CTRL, rd);
      compare("wb_dat_r CTRL", CTRL_RESET, rd);
      read_reg(REG_TLV_COUNT, rd);
      compare("wb_dat_r TLV_COUNT", 0, rd);
      read_reg(REG_FTR_COUNT, rd);
      compare("wb_dat_r FTR_COUNT", 0, rd);
      read_reg(REG_ID, rd);
      compare("wb_dat_r ID", TEST_ID, rd);
      write_reg(REG_CTRL, 32'h0000_0003);
      read_reg(REG_CTRL, rd);
      compare("wb_dat_r CTRL", 32'h0000_0003, rd);
      write_reg(REG_CTRL, CTRL_RESET);

      run_frames(frames_a, 1'b1, 1'b0);
      write_reg(REG_CTRL, 32'h0000_0000);  // With fixup off the words pass unchanged.
      run_frames(frames_b, 1'b0, 1'b0);
      write_reg(REG_CTRL, CTRL_RESET);

      rand_ready = 1'b1;
      run_frames(frames_c, 1'b1, 1'b1);
      rand_ready = 1'b0;

      read_reg(REG_TLV_COUNT, rd);
      compare("wb_dat_r TLV_COUNT",
              count_tlvs(frames_a) + count_tlvs(frames_b) + count_tlvs(frames_c), rd);
      read_reg(REG_FTR_COUNT, rd);
      compare("wb_dat_r FTR_COUNT",
              count_ftrs(frames_a) + count_ftrs(frames_b) + count_ftrs(frames_c), rd);
      read_reg(REG_INT_STATUS, rd);
      compare("wb_dat_r INT_STATUS", count_errs(frames_c) != 0, rd);

      write_reg(REG_CTRL, 32'h0000_0003);
      run_frames(frames_d, 1'b1, 1'b0);
      read_reg(REG_INT_STATUS, rd);
      compare("wb_dat_r INT_STATUS", count_errs(frames_d) != 0, rd);
      check_int(1'b1);
      write_reg(REG_CTRL, CTRL_RESET);
      check_int(1'b0);
      write_reg(REG_CTRL, 32'h0000_0003);
      check_int(1'b1);
      write_reg(REG_INT_STATUS, 32'h0000_0001);  // Write one to clear.
      read_reg(REG_INT_STATUS, rd);
      compare("wb_dat_r INT_STATUS", 0, rd);
      check_int(1'b0);

      repeat (4) @(posedge clk);
      if (errors == 0) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

endmodule

// ==== rtl/decomp_rst_sync.sv ====
module decomp_rst_sync (
   input  logic clk,
   input  logic rst_n,
   output logic rst_sync_n
);

   logic meta_n;

   // Assertion is immediate; release waits two clocks.
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         meta_n     <= 1'b0;
         rst_sync_n <= 1'b0;
      end else begin
         meta_n     <= 1'b1;
         rst_sync_n <= meta_n;
      end
   end

endmodule

// ==== rtl/stream_slice.sv ====
module stream_slice #(
   parameter type payload_t = logic
) (
   input  logic     clk,
   input  logic     rst_n,
   input  logic     in_valid,
   input  payload_t in_data,
   output logic     in_ready,
   output logic     out_valid,
   output payload_t out_data,
   input  logic     out_ready
);

   payload_t skid_data;
   logic     skid_valid;
   logic     in_xfer;
   logic     stall;

   assign in_xfer = in_valid && in_ready;
   assign stall   = out_valid && !out_ready;

   // The skid entry only fills while the main entry is stalled.
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         out_valid  <= 1'b0;
         skid_valid <= 1'b0;
         in_ready   <= 1'b0;
      end else if (skid_valid) begin
         if (out_ready) begin
            skid_valid <= 1'b0;
            in_ready   <= 1'b1;
         end
      end else if (in_xfer) begin
         if (stall) begin
            skid_valid <= 1'b1;
            in_ready   <= 1'b0;
         end else begin
            out_valid <= 1'b1;
            in_ready  <= 1'b1;
         end
      end else begin
         if (out_ready) out_valid <= 1'b0;
         in_ready <= 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (skid_valid) begin
         if (out_ready) out_data <= skid_data;
      end else if (in_xfer) begin
         if (stall) begin
            skid_data <= in_data;
         end else begin
            out_data <= in_data;
         end
      end
   end

   a_out_hold : assert property (
      @(posedge clk) disable iff (!rst_n)
      stall |=> out_valid && $stable(out_data)
   );

endmodule

// ==== rtl/xp10_decomp.sv ====
module xp10_decomp (
   input  logic                                     clk,
   input  logic                                     rst_n,
   input  logic                                     ib_tvalid,
   output logic                                     ib_tready,
   input  logic [xp10_decomp_pkg::DATA_W-1:0]       ib_tdata,
   input  logic [xp10_decomp_pkg::USER_W-1:0]       ib_tuser,
   input  logic                                     ib_tlast,
   output logic                                     ob_tvalid,
   input  logic                                     ob_tready,
   output logic [xp10_decomp_pkg::DATA_W-1:0]       ob_tdata,
   output logic [xp10_decomp_pkg::USER_W-1:0]       ob_tuser,
   output logic                                     ob_tlast,
   input  logic                                     wb_cyc,
   input  logic                                     wb_stb,
   input  logic                                     wb_we,
   input  logic [xp10_decomp_pkg::WB_ADR_W-1:0]     wb_adr,
   input  logic [xp10_decomp_pkg::WB_DAT_W-1:0]     wb_dat_w,
   output logic [xp10_decomp_pkg::WB_DAT_W-1:0]     wb_dat_r,
   output logic                                     wb_ack,
   input  logic [xp10_decomp_pkg::MODULE_ID_W-1:0]  module_id,
   output logic                                     decomp_int
);

   import xp10_decomp_pkg::*;

   logic              rst_sync_n;
   logic              core_tvalid;
   logic [DATA_W-1:0] core_tdata;
   logic [USER_W-1:0] core_tuser;
   logic              core_tlast;
   logic              slice_ready;
   logic              fixup_en;
   logic              tlv_event;
   logic              ftr_event;
   logic              tlv_err_event;
   stream_beat_t      slice_in;
   stream_beat_t      slice_out;

   decomp_rst_sync u_rst_sync (
      .clk        (clk),
      .rst_n      (rst_n),
      .rst_sync_n (rst_sync_n)
   );

   xp10_decomp_core u_core (
      .clk           (clk),
      .rst_n         (rst_sync_n),
      .in_tvalid     (ib_tvalid),
      .in_tdata      (ib_tdata),
      .in_tuser      (ib_tuser),
      .in_tlast      (ib_tlast),
      .in_tready     (ib_tready),
      .out_tvalid    (core_tvalid),
      .out_tdata     (core_tdata),
      .out_tuser     (core_tuser),
      .out_tlast     (core_tlast),
      .out_tready    (slice_ready),
      .fixup_en      (fixup_en),
      .tlv_event     (tlv_event),
      .ftr_event     (ftr_event),
      .tlv_err_event (tlv_err_event)
   );

   // Beats are packed into one payload for the output slice.
   assign slice_in = '{tdata: core_tdata, tuser: core_tuser, tlast: core_tlast};

   stream_slice #(
      .payload_t (stream_beat_t)
   ) u_ob_slice (
      .clk       (clk),
      .rst_n     (rst_sync_n),
      .in_valid  (core_tvalid),
      .in_data   (slice_in),
      .in_ready  (slice_ready),
      .out_valid (ob_tvalid),
      .out_data  (slice_out),
      .out_ready (ob_tready)
   );

   assign ob_tdata = slice_out.tdata;
   assign ob_tuser = slice_out.tuser;
   assign ob_tlast = slice_out.tlast;

   xp10_decomp_regfile u_regfile (
      .clk           (clk),
      .rst_n         (rst_sync_n),
      .wb_cyc        (wb_cyc),
      .wb_stb        (wb_stb),
      .wb_we         (wb_we),
      .wb_adr        (wb_adr),
      .wb_dat_w      (wb_dat_w),
      .wb_dat_r      (wb_dat_r),
      .wb_ack        (wb_ack),
      .module_id     (module_id),
      .tlv_event     (tlv_event),
      .ftr_event     (ftr_event),
      .tlv_err_event (tlv_err_event),
      .fixup_en      (fixup_en),
      .decomp_int    (decomp_int)
   );

endmodule

// ==== rtl/xp10_decomp_core.sv ====
module xp10_decomp_core (
   input  logic                                clk,
   input  logic                                rst_n,
   input  logic                                in_tvalid,
   input  logic [xp10_decomp_pkg::DATA_W-1:0]  in_tdata,
   input  logic [xp10_decomp_pkg::USER_W-1:0]  in_tuser,
   input  logic                                in_tlast,
   output logic                                in_tready,
   output logic                                out_tvalid,
   output logic [xp10_decomp_pkg::DATA_W-1:0]  out_tdata,
   output logic [xp10_decomp_pkg::USER_W-1:0]  out_tuser,
   output logic                                out_tlast,
   input  logic                                out_tready,
   input  logic                                fixup_en,
   output logic                                tlv_event,
   output logic                                ftr_event,
   output logic                                tlv_err_event
);

   import xp10_decomp_pkg::*;

   localparam int HALF_W = DATA_W / 2;

   logic                 xfer;
   logic                 sot;
   logic                 eot;
   logic                 start_is_ftr;
   logic                 cur_is_ftr;
   logic                 fixup_word;
   logic                 in_ftr;
   logic                 in_tlv;
   logic [FTR_IDX_W-1:0] ftr_idx;
   logic [FTR_IDX_W-1:0] cur_idx;

   // In stored mode the word stream flows straight through.
   assign in_tready  = out_tready;
   assign out_tvalid = in_tvalid;
   assign out_tuser  = in_tuser;
   assign out_tlast  = in_tlast;

   assign xfer = in_tvalid && out_tready;
   assign sot  = in_tuser[USER_SOT];
   assign eot  = in_tuser[USER_EOT];

   assign start_is_ftr = sot && (in_tdata[7:0] == TLV_TYPE_FTR);

   // A start word opens a new TLV at index 0, whatever came before it.
   assign cur_is_ftr = sot ? start_is_ftr : in_ftr;
   assign cur_idx    = sot ? '0 : ftr_idx;

   assign fixup_word = fixup_en && cur_is_ftr && (cur_idx == FTR_IDX_W'(FTR_WORD_IDX));

   always_comb begin
      out_tdata = in_tdata;
      if (fixup_word) begin
         out_tdata[DATA_W-1:HALF_W] = in_tdata[HALF_W-1:0];  // bytes_out takes bytes_in.
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         in_tlv  <= 1'b0;
         in_ftr  <= 1'b0;
         ftr_idx <= '0;
      end else if (xfer) begin
         in_tlv <= (sot || in_tlv) && !eot;
         in_ftr <= cur_is_ftr && !eot;
         // Long TLVs park at the top value so word 12 is never matched twice.
         if (cur_idx == '1) begin
            ftr_idx <= cur_idx;
         end else begin
            ftr_idx <= cur_idx + 1'b1;
         end
      end
   end

   assign tlv_event = xfer && sot;
   assign ftr_event = xfer && start_is_ftr;

   // A footer that closes before its byte counts arrived is malformed.
   assign tlv_err_event = xfer && cur_is_ftr && eot &&
                          (cur_idx < FTR_IDX_W'(FTR_WORD_IDX));

   a_eot_inside_tlv : assert property (
      @(posedge clk) disable iff (!rst_n)
      xfer && eot |-> sot || in_tlv
   );

endmodule

// ==== rtl/xp10_decomp_pkg.sv ====
package xp10_decomp_pkg;

   // Stream geometry.
   localparam int DATA_W = 64;
   localparam int USER_W = 2;
   localparam int USER_SOT = 0;   // First word of a TLV.
   localparam int USER_EOT = 1;   // Last word of a TLV.

   // TLV type codes live in data bits 7:0 of the first word.
   localparam logic [7:0] TLV_TYPE_FTR = 8'h09;

   // Footer word 12 carries bytes_in in 31:0 and bytes_out in 63:32.
   localparam int FTR_WORD_IDX = 12;
   localparam int FTR_IDX_W = 4;  // Saturates at 15, past the fixup word.

   localparam int MODULE_ID_W = 8;

   // Wishbone register port.
   localparam int WB_ADR_W = 3;
   localparam int WB_DAT_W = 32;

   localparam logic [WB_ADR_W-1:0] REG_CTRL       = 3'd0;
   localparam logic [WB_ADR_W-1:0] REG_INT_STATUS = 3'd1;
   localparam logic [WB_ADR_W-1:0] REG_TLV_COUNT  = 3'd2;
   localparam logic [WB_ADR_W-1:0] REG_FTR_COUNT  = 3'd3;
   localparam logic [WB_ADR_W-1:0] REG_ID         = 3'd4;

   localparam logic [WB_DAT_W-1:0] CTRL_RESET = 32'h0000_0001;
   localparam int CTRL_FIXUP_EN_BIT  = 0;
   localparam int CTRL_ERR_INT_EN_BIT = 1;

   localparam int INT_TLV_ERR_BIT = 0;

   // One beat of the stream as carried through the output register slice.
   typedef struct packed {
      logic [DATA_W-1:0] tdata;
      logic [USER_W-1:0] tuser;
      logic              tlast;
   } stream_beat_t;

endpackage

// ==== rtl/xp10_decomp_regfile.sv ====
module xp10_decomp_regfile (
   input  logic                                     clk,
   input  logic                                     rst_n,
   input  logic                                     wb_cyc,
   input  logic                                     wb_stb,
   input  logic                                     wb_we,
   input  logic [xp10_decomp_pkg::WB_ADR_W-1:0]     wb_adr,
   input  logic [xp10_decomp_pkg::WB_DAT_W-1:0]     wb_dat_w,
   output logic [xp10_decomp_pkg::WB_DAT_W-1:0]     wb_dat_r,
   output logic                                     wb_ack,
   input  logic [xp10_decomp_pkg::MODULE_ID_W-1:0]  module_id,
   input  logic                                     tlv_event,
   input  logic                                     ftr_event,
   input  logic                                     tlv_err_event,
   output logic                                     fixup_en,
   output logic                                     decomp_int
);

   import xp10_decomp_pkg::*;

   logic                req;
   logic                wr_en;
   logic                int_clr;
   logic [WB_DAT_W-1:0] ctrl;
   logic                tlv_err_sts;
   logic [WB_DAT_W-1:0] tlv_count;
   logic [WB_DAT_W-1:0] ftr_count;
   logic [WB_DAT_W-1:0] rd_data;

   // A new request is only taken when no ack is pending, so ack is one cycle wide.
   assign req     = wb_cyc && wb_stb && !wb_ack;
   assign wr_en   = req && wb_we;
   assign int_clr = wr_en && (wb_adr == REG_INT_STATUS) && wb_dat_w[INT_TLV_ERR_BIT];

   assign fixup_en = ctrl[CTRL_FIXUP_EN_BIT];

   always_comb begin
      rd_data = '0;
      case (wb_adr)
         REG_CTRL:       rd_data = ctrl;
         REG_INT_STATUS: rd_data[INT_TLV_ERR_BIT] = tlv_err_sts;
         REG_TLV_COUNT:  rd_data = tlv_count;
         REG_FTR_COUNT:  rd_data = ftr_count;
         REG_ID:         rd_data = WB_DAT_W'(module_id);
         default:        rd_data = '0;
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wb_ack <= 1'b0;
         ctrl   <= CTRL_RESET;
      end else begin
         wb_ack <= req;
         if (wr_en && (wb_adr == REG_CTRL)) ctrl <= wb_dat_w;
      end
   end

   // Read data is captured with the ack and held until the next request.
   always_ff @(posedge clk) begin
      if (req && !wb_we) begin
         wb_dat_r <= rd_data;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         tlv_err_sts <= 1'b0;
      end else if (tlv_err_event) begin
         tlv_err_sts <= 1'b1;  // A new error beats a clear in the same cycle.
      end else if (int_clr) begin
         tlv_err_sts <= 1'b0;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         tlv_count <= '0;
         ftr_count <= '0;
      end else begin
         if (tlv_event) tlv_count <= tlv_count + 1'b1;
         if (ftr_event) ftr_count <= ftr_count + 1'b1;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         decomp_int <= 1'b0;
      end else begin
         decomp_int <= tlv_err_sts && ctrl[CTRL_ERR_INT_EN_BIT];
      end
   end

   a_ack_single : assert property (
      @(posedge clk) disable iff (!rst_n)
      wb_ack |=> !wb_ack
   );

endmodule

// ==== sim.f ====
+incdir+bench
rtl/xp10_decomp_pkg.sv
rtl/decomp_rst_sync.sv
rtl/xp10_decomp_core.sv
rtl/stream_slice.sv
rtl/xp10_decomp_regfile.sv
rtl/xp10_decomp.sv
bench/xp10_decomp_tb.sv
